// ==== Bender.yml ====
package:
  name: core

sources:
  - files:
      - hw/core_pkg.sv
      - hw/main_decoder.sv
      - hw/alu_decoder.sv
      - hw/alu.sv
      - hw/imm_extend.sv
      - hw/reg_file.sv
      - hw/core_top.sv
  - target: simulation
    files:
      - sim/core_chk.sv
      - sim/core_tb.sv

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [core_pkg::XLEN-1:0] a_i,
    input  logic [core_pkg::XLEN-1:0] b_i,
    input  core_pkg::alu_ctrl_e       ctrl_i,
    output logic [core_pkg::XLEN-1:0] result_o,
    output logic                      zero_o
);

    logic [4:0] shamt;                               // Low 5 bits of b

    assign shamt = b_i[4:0];

    always_comb
    begin
        case (ctrl_i)
            core_pkg::ALU_ADD:   result_o = a_i + b_i;
            core_pkg::ALU_SUB:   result_o = a_i - b_i;
            core_pkg::ALU_AND:   result_o = a_i & b_i;
            core_pkg::ALU_OR:    result_o = a_i | b_i;
            core_pkg::ALU_XOR:   result_o = a_i ^ b_i;
            core_pkg::ALU_SLT:
            begin
                result_o = {{(core_pkg::XLEN-1){1'b0}}, ($signed(a_i) < $signed(b_i))};
            end
            core_pkg::ALU_SLTU:
            begin
                result_o = {{(core_pkg::XLEN-1){1'b0}}, (a_i < b_i)};
            end
            core_pkg::ALU_SLL:   result_o = a_i << shamt;
            core_pkg::ALU_SRL:   result_o = a_i >> shamt;
            core_pkg::ALU_SRA:   result_o = $unsigned($signed(a_i) >>> shamt);
            core_pkg::ALU_PASSB: result_o = b_i;    // LUI
            default:             result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0);               // Equal flag for branches

endmodule

// ==== hw/alu_decoder.sv ====
`timescale 1ns/1ps

module alu_decoder (
    input  core_pkg::alu_op_e         alu_op_i,
    input  logic              [2:0]   funct3_i,
    input  logic                      funct7_b5_i,
    input  logic                      op_b5_i,     // Set for R-type
    output core_pkg::alu_ctrl_e       alu_ctrl_o
);

    always_comb
    begin
        case (alu_op_i)
            core_pkg::ALUOP_ADD:    alu_ctrl_o = core_pkg::ALU_ADD;
            core_pkg::ALUOP_BRANCH: alu_ctrl_o = core_pkg::ALU_SUB;
            core_pkg::ALUOP_PASSB:  alu_ctrl_o = core_pkg::ALU_PASSB;
            default:
            begin
                case (funct3_i)
                    3'b000:
                    begin
                        // ADDI has no subtract form
                        if (funct7_b5_i && op_b5_i)
                            alu_ctrl_o = core_pkg::ALU_SUB;
                        else
                            alu_ctrl_o = core_pkg::ALU_ADD;
                    end
                    3'b001:  alu_ctrl_o = core_pkg::ALU_SLL;
                    3'b010:  alu_ctrl_o = core_pkg::ALU_SLT;
                    3'b011:  alu_ctrl_o = core_pkg::ALU_SLTU;
                    3'b100:  alu_ctrl_o = core_pkg::ALU_XOR;
                    3'b101:
                    begin
                        if (funct7_b5_i)           // Also bit 10 of SRAI
                            alu_ctrl_o = core_pkg::ALU_SRA;
                        else
                            alu_ctrl_o = core_pkg::ALU_SRL;
                    end
                    3'b110:  alu_ctrl_o = core_pkg::ALU_OR;
                    default: alu_ctrl_o = core_pkg::ALU_AND;
                endcase
            end
        endcase
    end

endmodule

// ==== hw/core_pkg.sv ====
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NREGS      = 1 << REG_ADDR_W;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_OP     = 7'b0110011,
        OP_OP_IMM = 7'b0010011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } imm_src_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,              // ALU result
        RES_MEM = 2'b01,              // Load data
        RES_PC4 = 2'b10               // Link value
    } result_src_e;

    typedef enum logic [1:0] {
        ALUOP_ADD    = 2'b00,         // Address calculation
        ALUOP_BRANCH = 2'b01,         // Compare by subtraction
        ALUOP_FUNC   = 2'b10,         // Decode from funct fields
        ALUOP_PASSB  = 2'b11          // LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLT   = 4'd5,
        ALU_SLTU  = 4'd6,
        ALU_SLL   = 4'd7,
        ALU_SRL   = 4'd8,
        ALU_SRA   = 4'd9,
        ALU_PASSB = 4'd10
    } alu_ctrl_e;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        logic        mem_write;
        logic        alu_src_imm;     // Operand B is the immediate
        logic        alu_a_pc;        // Operand A is the pc
        imm_src_e    imm_src;
        alu_op_e     alu_op;
        logic        jalr;            // Next pc from the ALU
    } ctrl_t;

    // Control word of an instruction that does nothing
    localparam ctrl_t CTRL_NOP = '{
        reg_write:   1'b0,
        result_src:  RES_ALU,
        mem_write:   1'b0,
        alu_src_imm: 1'b0,
        alu_a_pc:    1'b0,
        imm_src:     IMM_I,
        alu_op:      ALUOP_ADD,
        jalr:        1'b0
    };

endpackage

// ==== hw/core_top.sv ====
`timescale 1ns/1ps

module core_top (
    input  logic                      clk_i,
    input  logic                      reset_i,
    output logic [core_pkg::XLEN-1:0] imem_addr_o,
    input  logic [core_pkg::XLEN-1:0] imem_data_i,
    output logic [core_pkg::XLEN-1:0] dmem_addr_o,
    output logic [core_pkg::XLEN-1:0] dmem_wdata_o,
    output logic                      dmem_we_o,
    input  logic [core_pkg::XLEN-1:0] dmem_rdata_i
);

    logic [core_pkg::XLEN-1:0] pc;
    logic [core_pkg::XLEN-1:0] pc_next;
    logic [core_pkg::XLEN-1:0] pc_plus4;
    logic [core_pkg::XLEN-1:0] pc_target;           // pc plus immediate
    logic [core_pkg::XLEN-1:0] instr;
    core_pkg::ctrl_t           ctrl;
    core_pkg::alu_ctrl_e       alu_ctrl;
    logic                      pc_src;
    logic                      zero;
    logic [core_pkg::XLEN-1:0] imm;
    logic [core_pkg::XLEN-1:0] rs1_data;
    logic [core_pkg::XLEN-1:0] rs2_data;
    logic [core_pkg::XLEN-1:0] alu_a;
    logic [core_pkg::XLEN-1:0] alu_b;
    logic [core_pkg::XLEN-1:0] alu_result;
    logic [core_pkg::XLEN-1:0] result;              // Writeback value

    assign instr       = imem_data_i;
    assign imem_addr_o = pc;

    main_decoder main_decoder0 (
        .op_i     (instr[6:0]),
        .funct3_i (instr[14:12]),
        .eq_i     (zero),
        .ctrl_o   (ctrl),
        .pc_src_o (pc_src)
    );

    alu_decoder alu_decoder0 (
        .alu_op_i    (ctrl.alu_op),
        .funct3_i    (instr[14:12]),
        .funct7_b5_i (instr[30]),
        .op_b5_i     (instr[5]),
        .alu_ctrl_o  (alu_ctrl)
    );

    imm_extend imm_extend0 (
        .instr_i   (instr[31:7]),
        .imm_src_i (ctrl.imm_src),
        .imm_o     (imm)
    );

    reg_file reg_file0 (
        .clk_i    (clk_i),
        .raddr1_i (instr[19:15]),
        .raddr2_i (instr[24:20]),
        .waddr_i  (instr[11:7]),
        .we_i     (ctrl.reg_write),
        .wdata_i  (result),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    assign alu_a = ctrl.alu_a_pc ? pc : rs1_data;       // pc only for AUIPC
    assign alu_b = ctrl.alu_src_imm ? imm : rs2_data;

    alu alu0 (
        .a_i      (alu_a),
        .b_i      (alu_b),
        .ctrl_i   (alu_ctrl),
        .result_o (alu_result),
        .zero_o   (zero)
    );

    always_comb
    begin
        case (ctrl.result_src)
            core_pkg::RES_MEM: result = dmem_rdata_i;
            core_pkg::RES_PC4: result = pc_plus4;        // Link for JAL and JALR
            default:           result = alu_result;
        endcase
    end

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;

    always_comb
    begin
        if (ctrl.jalr)
            pc_next = {alu_result[core_pkg::XLEN-1:1], 1'b0};
        else if (pc_src)
            pc_next = pc_target;
        else
            pc_next = pc_plus4;
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
            pc <= '0;
        else
            pc <= pc_next;
    end

    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rs2_data;
    assign dmem_we_o    = ctrl.mem_write & ~reset_i;    // No stores during reset

endmodule

// ==== hw/imm_extend.sv ====
`timescale 1ns/1ps

module imm_extend (
    input  logic                [31:7]           instr_i,
    input  core_pkg::imm_src_e                   imm_src_i,
    output logic                [core_pkg::XLEN-1:0] imm_o
);

    logic sign;                                      // Instruction bit 31

    assign sign = instr_i[31];

    always_comb
    begin
        case (imm_src_i)
            core_pkg::IMM_I:
                imm_o = {{20{sign}}, instr_i[31:20]};
            core_pkg::IMM_S:
                imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            core_pkg::IMM_B:
                imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            core_pkg::IMM_J:
                imm_o = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            core_pkg::IMM_U:
                imm_o = {instr_i[31:12], 12'b0};   // Upper 20 bits
            default:
                imm_o = '0;
        endcase
    end

endmodule

// ==== hw/main_decoder.sv ====
`timescale 1ns/1ps

module main_decoder (
    input  logic              [6:0] op_i,     // Opcode bits
    input  logic              [2:0] funct3_i, // Branch condition select
    input  logic                    eq_i,     // ALU zero flag
    output core_pkg::ctrl_t         ctrl_o,
    output logic                    pc_src_o  // Next pc is pc plus immediate
);

    core_pkg::opcode_e opcode;
    logic              branch;                // Conditional branch
    logic              jal;                   // Unconditional jump to pc plus immediate

    assign opcode = core_pkg::opcode_e'(op_i);

    always_comb
    begin
        ctrl_o = core_pkg::CTRL_NOP;
        branch = 1'b0;
        jal    = 1'b0;
        case (opcode)
            core_pkg::OP_LOAD:
            begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.result_src  = core_pkg::RES_MEM;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.imm_src     = core_pkg::IMM_I;
                ctrl_o.alu_op      = core_pkg::ALUOP_ADD;
            end
            core_pkg::OP_STORE:
            begin
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.imm_src     = core_pkg::IMM_S;
                ctrl_o.alu_op      = core_pkg::ALUOP_ADD;
            end
            core_pkg::OP_OP:
            begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.result_src = core_pkg::RES_ALU;
                ctrl_o.alu_op     = core_pkg::ALUOP_FUNC;
            end
            core_pkg::OP_OP_IMM:
            begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.result_src  = core_pkg::RES_ALU;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.imm_src     = core_pkg::IMM_I;
                ctrl_o.alu_op      = core_pkg::ALUOP_FUNC;
            end
            core_pkg::OP_BRANCH:
            begin
                ctrl_o.imm_src = core_pkg::IMM_B;   // Target is pc plus B immediate
                ctrl_o.alu_op  = core_pkg::ALUOP_BRANCH;
                branch         = 1'b1;
            end
            core_pkg::OP_JAL:
            begin
                ctrl_o.reg_write  = 1'b1;
                ctrl_o.result_src = core_pkg::RES_PC4;
                ctrl_o.imm_src    = core_pkg::IMM_J;
                jal               = 1'b1;
            end
            core_pkg::OP_JALR:
            begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.result_src  = core_pkg::RES_PC4;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.imm_src     = core_pkg::IMM_I;
                ctrl_o.alu_op      = core_pkg::ALUOP_ADD; // rs1 plus offset
                ctrl_o.jalr        = 1'b1;
            end
            core_pkg::OP_LUI:
            begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.result_src  = core_pkg::RES_ALU;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.imm_src     = core_pkg::IMM_U;
                ctrl_o.alu_op      = core_pkg::ALUOP_PASSB;
            end
            core_pkg::OP_AUIPC:
            begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.result_src  = core_pkg::RES_ALU;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_a_pc    = 1'b1;             // pc plus U immediate
                ctrl_o.imm_src     = core_pkg::IMM_U;
                ctrl_o.alu_op      = core_pkg::ALUOP_ADD;
            end
            default:
            begin
                ctrl_o = core_pkg::CTRL_NOP;
            end
        endcase
    end

    // Branch resolution from the zero flag of rs1 minus rs2
    always_comb
    begin
        if (jal)
        begin
            pc_src_o = 1'b1;
        end
        else
        begin
            case (funct3_i)
                3'b000:  pc_src_o = branch & eq_i;   // BEQ
                3'b001:  pc_src_o = branch & ~eq_i;  // BNE
                default: pc_src_o = 1'b0;
            endcase
        end
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                            clk_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr2_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic                            we_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i,
    output logic [core_pkg::XLEN-1:0]       rdata1_o,
    output logic [core_pkg::XLEN-1:0]       rdata2_o
);

    logic [core_pkg::XLEN-1:0] regs [core_pkg::NREGS];

    always_ff @(posedge clk_i)
    begin
        if (we_i && (waddr_i != '0))          // x0 stays zero
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous read ports
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== sim.f ====
hw/core_pkg.sv
hw/main_decoder.sv
hw/alu_decoder.sv
hw/alu.sv
hw/imm_extend.sv
hw/reg_file.sv
hw/core_top.sv
sim/core_chk.sv
sim/core_tb.sv

// ==== sim/core_chk.sv ====
`timescale 1ns/1ps

module core_chk (
    input logic                      clk_i,
    input logic                      reset_i,
    input logic [core_pkg::XLEN-1:0] imem_addr_i,
    input logic                      dmem_we_i
);

    assert property (@(posedge clk_i) reset_i |-> !dmem_we_i)
        else $error("dmem_we_o high while reset_i is high");

    // Fetch stays word aligned
    assert property (@(posedge clk_i) disable iff (reset_i) imem_addr_i[1:0] == 2'b00)
        else $error("imem_addr_o not word aligned");

    assert property (@(posedge clk_i) reset_i |=> imem_addr_i == '0)
        else $error("pc not zero in the cycle after reset");

endmodule

bind core_top core_chk core_chk0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .imem_addr_i (imem_addr_o),
    .dmem_we_i   (dmem_we_o)
);

// ==== sim/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

    localparam int          RESET_CYCLES = 16;
    localparam int          DMEM_WORDS   = 64;
    localparam logic [31:0] SEED         = 32'he1df2e2b;

    typedef struct packed {
        logic [core_pkg::XLEN-1:0] pc;                 // Expected fetch address
        logic [core_pkg::XLEN-1:0] instr;
        logic                      we;
        logic [core_pkg::XLEN-1:0] addr;               // Store address
        logic [core_pkg::XLEN-1:0] data;               // Store data
    } row_t;

    logic                      clk = 1'b0;
    logic                      reset;
    logic [core_pkg::XLEN-1:0] imem_addr;
    logic [core_pkg::XLEN-1:0] imem_data;
    logic [core_pkg::XLEN-1:0] dmem_addr;
    logic [core_pkg::XLEN-1:0] dmem_wdata;
    logic                      dmem_we;
    logic [core_pkg::XLEN-1:0] dmem_rdata;
    logic [core_pkg::XLEN-1:0] dmem [DMEM_WORDS];      // Data memory model
    row_t                      rows [$];
    logic [core_pkg::XLEN-1:0] build_pc;               // pc of the next table row
    logic [core_pkg::XLEN-1:0] store_addr;             // Next free result slot
    int                        errors = 0;
    int                        checks = 0;
    int                        cycles = 0;
    int                        limit  = 0;

    core_top dut0 (
        .clk_i        (clk),
        .reset_i      (reset),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we),
        .dmem_rdata_i (dmem_rdata)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        if (dmem_we)
            dmem[dmem_addr[7:2]] <= dmem_wdata;       // Stores land on the rising edge
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= limit)
        begin
            $display("Timeout after %0d cycles before the table was finished", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, core_pkg::OP_OP};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input core_pkg::opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], core_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, core_pkg::OP_JAL};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                          input core_pkg::opcode_e op);
        return {imm, rd, op};
    endfunction

    task automatic add_row(input logic [31:0] instr, input logic we,
                           input logic [31:0] addr, input logic [31:0] data);
        rows.push_back(row_t'{build_pc, instr, we, addr, data});
        build_pc = build_pc + 32'd4;
    endtask

    task automatic step(input logic [31:0] instr);
        add_row(instr, 1'b0, '0, '0);
    endtask

    // SW of rs2 to the next result slot off x0
    task automatic store(input logic [4:0] rs2, input logic [31:0] exp);
        add_row(stype(store_addr[11:0], rs2, 5'd0), 1'b1, store_addr, exp);
        store_addr = store_addr + 32'd4;
    endtask

    task automatic jump(input logic [31:0] instr, input logic [31:0] off);
        add_row(instr, 1'b0, '0, '0);
        build_pc = build_pc - 32'd4 + off;             // Successor at pc plus off
    endtask

    task automatic check_word(input string name, input logic [core_pkg::XLEN-1:0] exp,
                              input logic [core_pkg::XLEN-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[FAIL] %s expected %h got %h at pc %h", name, exp, act, imem_addr);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[FAIL] %s expected %h got %h at pc %h", name, exp, act, imem_addr);
        end
    endtask

    task automatic build_table();
        logic [31:0] link_pc;
        logic [31:0] auipc_pc;
        build_pc   = '0;
        store_addr = '0;
        step(itype(12'd100, 5'd0, 3'b000, 5'd1, core_pkg::OP_OP_IMM));     // x1 = 100
        step(itype(12'd7, 5'd0, 3'b000, 5'd2, core_pkg::OP_OP_IMM));       // x2 = 7
        step(itype(12'hff0, 5'd0, 3'b000, 5'd5, core_pkg::OP_OP_IMM));     // x5 = -16
        step(rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));                       // ADD
        store(5'd3, 32'd107);
        step(rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));                       // SUB
        store(5'd4, 32'd93);
        step(rtype(7'h00, 5'd5, 5'd1, 3'b111, 5'd6));                       // AND
        store(5'd6, 32'h0000_0060);
        step(rtype(7'h00, 5'd5, 5'd1, 3'b100, 5'd7));                       // XOR
        store(5'd7, 32'hffff_ff94);
        step(rtype(7'h00, 5'd1, 5'd5, 3'b010, 5'd8));                       // Signed -16 below 100
        store(5'd8, 32'd1);
        step(rtype(7'h00, 5'd1, 5'd5, 3'b011, 5'd9));                       // Unsigned not below
        store(5'd9, 32'd0);
        step(rtype(7'h00, 5'd2, 5'd2, 3'b001, 5'd10));                      // SLL 7 by 7
        store(5'd10, 32'h0000_0380);
        step(rtype(7'h00, 5'd2, 5'd5, 3'b101, 5'd11));                      // SRL
        store(5'd11, 32'h01ff_ffff);
        step(rtype(7'h20, 5'd2, 5'd5, 3'b101, 5'd12));                      // SRA
        store(5'd12, 32'hffff_ffff);
        step(itype(12'h402, 5'd5, 3'b101, 5'd13, core_pkg::OP_OP_IMM));     // SRAI by 2
        store(5'd13, 32'hffff_fffc);
        step(itype(12'h070, 5'd2, 3'b110, 5'd14, core_pkg::OP_OP_IMM));     // ORI
        store(5'd14, 32'h0000_0077);
        step(itype(12'hfff, 5'd1, 3'b011, 5'd15, core_pkg::OP_OP_IMM));     // SLTIU against all ones
        store(5'd15, 32'd1);
        step(itype(12'd5, 5'd0, 3'b000, 5'd0, core_pkg::OP_OP_IMM));        // Write to x0
        store(5'd0, 32'd0);
        add_row(stype(12'h01c, 5'd3, 5'd1), 1'b1, 32'h0000_0080, 32'd107);  // x1 plus 0x1c
        step(itype(12'h01c, 5'd1, 3'b010, 5'd16, core_pkg::OP_LOAD));
        store(5'd16, 32'd107);
        step(itype(12'h05c, 5'd1, 3'b010, 5'd17, core_pkg::OP_LOAD));       // Untouched word 0xc0
        store(5'd17, dmem[48]);
        jump(btype(13'd12, 5'd1, 5'd1, 3'b000), 32'd12);                    // BEQ taken
        step(btype(13'd12, 5'd2, 5'd1, 3'b000));                            // BEQ not taken
        jump(btype(13'd16, 5'd2, 5'd1, 3'b001), 32'd16);                    // BNE taken
        step(btype(13'd16, 5'd1, 5'd1, 3'b001));                            // BNE not taken
        link_pc = build_pc;
        jump(jtype(21'd20, 5'd18), 32'd20);                                 // JAL x18
        store(5'd18, link_pc + 32'd4);
        // x19 holds the JALR pc plus 16 and the odd offset 9 lands 24 ahead
        step(itype(build_pc[11:0] + 12'd20, 5'd0, 3'b000, 5'd19, core_pkg::OP_OP_IMM));
        link_pc = build_pc;
        jump(itype(12'd9, 5'd19, 3'b000, 5'd20, core_pkg::OP_JALR), 32'd24);
        store(5'd20, link_pc + 32'd4);
        step(utype(20'h12345, 5'd21, core_pkg::OP_LUI));
        store(5'd21, 32'h1234_5000);
        auipc_pc = build_pc;
        step(utype(20'h80001, 5'd22, core_pkg::OP_AUIPC));
        store(5'd22, auipc_pc + 32'h8000_1000);
    endtask

    initial
    begin
        row_t cur;
        int   i;
        reset      = 1'b1;
        imem_data  = stype(12'h000, 5'd1, 5'd0);      // Store that reset must hold off
        dmem_rdata = '0;
        void'($urandom(SEED));
        for (i = 0; i < DMEM_WORDS; i++)
            dmem[i] = $urandom;
        build_table();
        limit = (RESET_CYCLES + rows.size()) * 4;
        repeat (RESET_CYCLES)
        begin
            @(negedge clk);
            check_bit("dmem_we_o", 1'b0, dmem_we);
        end
        reset = 1'b0;
        for (i = 0; i < rows.size(); i++)
        begin
            if (i > 0)
                @(negedge clk);
            cur = rows[i];
            check_word("imem_addr_o", cur.pc, imem_addr);
            imem_data = cur.instr;
            #1;
            dmem_rdata = dmem[dmem_addr[7:2]];
            #1;
            check_bit("dmem_we_o", cur.we, dmem_we);
            if (cur.we)
            begin
                check_word("dmem_addr_o", cur.addr, dmem_addr);
                check_word("dmem_wdata_o", cur.data, dmem_wdata);
            end
        end
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule
